// File: Makefile
# Verilator build and run of the bridge testbench

VERILATOR ?= verilator
TOP       ?= bridge_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench, fails on a failing run"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

// File: filelist.f
source/bridge_pkg.sv
source/bridge_cmd_if.sv
source/axi_front_end.sv
source/cmd_queue.sv
source/ahb_master.sv
source/axi_to_ahb_bridge.sv
tests/ahb_slave_model.sv
tests/bridge_tb.sv

// File: source/ahb_master.sv
/*
 * AHB-Lite master: one transfer at a time, byte splitting of
 * scattered write strobes, AXI B and R response channels
 */
`timescale 1ns/1ns
`default_nettype none

module ahb_master #(
   parameter int ID_WIDTH = 4
) (
   input  wire logic                           bus_clk,
   input  wire logic                           rst,

   bridge_cmd_if.sink                          cmd,

   output logic [bridge_pkg::ADDR_W-1:0]       haddr,
   output logic [2:0]                          hsize,
   output logic [1:0]                          htrans,
   output logic                                hwrite,
   output logic [bridge_pkg::DATA_W-1:0]       hwdata,
   input  wire logic [bridge_pkg::DATA_W-1:0]  hrdata,
   input  wire logic                           hready,
   input  wire logic                           hresp,

   output logic                                bvalid,
   input  wire logic                           bready,
   output logic [ID_WIDTH-1:0]                 bid,
   output logic [1:0]                          bresp,

   output logic                                rvalid,
   input  wire logic                           rready,
   output logic [ID_WIDTH-1:0]                 rid,
   output logic [bridge_pkg::DATA_W-1:0]       rdata,
   output logic [1:0]                          rresp
);
   import bridge_pkg::*;

   localparam logic [2:0] ST_IDLE    = 3'd0;
   localparam logic [2:0] ST_ADDR    = 3'd1;
   localparam logic [2:0] ST_DATA    = 3'd2;
   localparam logic [2:0] ST_RESP_RD = 3'd3;
   localparam logic [2:0] ST_RESP_WR = 3'd4;

   logic [2:0]          state;
   logic [2:0]          state_nxt;

   // Current command
   logic                cur_write;
   logic [ID_WIDTH-1:0] cur_id;
   logic [ADDR_W-1:0]   cur_addr;
   logic [2:0]          cur_size;
   logic [STRB_W-1:0]   cur_strb;
   logic [DATA_W-1:0]   cur_wdata;
   logic [DATA_W-1:0]   rdata_q;
   logic                err;

   logic [2:0]          lane;       // Byte lane of the split write
   logic [2:0]          first_lane;
   logic                first_found;
   logic [2:0]          nxt_lane;
   logic                nxt_found;
   logic                more_lanes;
   logic                split;
   logic                cmd_take;
   logic                xfer_done;

   assign cmd.ready = (state == ST_IDLE);
   assign cmd_take  = cmd.valid & cmd.ready;
   assign xfer_done = (state == ST_DATA) & hready;
   assign split     = cur_write & ~strb_is_aligned(cur_strb);

   always_comb begin
      first_lane = next_lane(cmd.strb, 3'd0, first_found);
      nxt_lane   = next_lane(cur_strb, lane + 3'd1, nxt_found);
      more_lanes = nxt_found & (lane != 3'd7);  // Lane 7 has nothing above it
   end

   //*******************************************************************
   // Transfer sequencer
   //*******************************************************************
   always_comb begin
      state_nxt = state;
      case (state)
         ST_IDLE: begin
            if (cmd.valid) begin
               // Empty strobe has nothing to send on AHB
               if (cmd.write && !strb_is_aligned(cmd.strb) && !first_found)
                  state_nxt = ST_RESP_WR;
               else
                  state_nxt = ST_ADDR;
            end
         end
         ST_ADDR: state_nxt = ST_DATA;
         ST_DATA: begin
            if (hready) begin
               if (!cur_write)
                  state_nxt = ST_RESP_RD;
               else if (!hresp && split && more_lanes)
                  state_nxt = ST_ADDR;  // Next byte of the scattered write
               else
                  state_nxt = ST_RESP_WR;
            end
         end
         ST_RESP_RD: if (rready) state_nxt = ST_IDLE;
         ST_RESP_WR: if (bready) state_nxt = ST_IDLE;
         default:    state_nxt = ST_IDLE;
      endcase
   end

   always_ff @(posedge bus_clk) begin
      if (rst) begin
         state <= ST_IDLE;
         err   <= 1'b0;
      end else begin
         state <= state_nxt;
         if (cmd_take)
            err <= 1'b0;
         else if (xfer_done && hresp)
            err <= 1'b1;
      end
   end

   always_ff @(posedge bus_clk) begin
      if (cmd_take) begin
         cur_write <= cmd.write;
         cur_id    <= cmd.id;
         cur_addr  <= cmd.addr;
         cur_size  <= cmd.size;
         cur_strb  <= cmd.strb;
         cur_wdata <= cmd.wdata;
         lane      <= first_lane;
      end else if (xfer_done && !hresp && more_lanes) begin
         lane <= nxt_lane;
      end

      if (xfer_done)
         rdata_q <= hresp ? '0 : hrdata;  // Errored read returns zero
   end

   //*******************************************************************
   // AHB outputs
   //*******************************************************************
   assign htrans = (state == ST_ADDR) ? HTRANS_NONSEQ : HTRANS_IDLE;
   assign haddr  = split ? {cur_addr[ADDR_W-1:3], lane} : cur_addr;
   assign hsize  = cur_size;   // Byte for split writes
   assign hwrite = cur_write;
   assign hwdata = cur_wdata;

   // AXI responses
   assign bvalid = (state == ST_RESP_WR);
   assign bid    = cur_id;
   assign bresp  = err ? RESP_SLVERR : RESP_OKAY;

   assign rvalid = (state == ST_RESP_RD);
   assign rid    = cur_id;
   assign rdata  = rdata_q;
   assign rresp  = err ? RESP_SLVERR : RESP_OKAY;

endmodule

`default_nettype wire

// File: source/axi_front_end.sv
/*
 * AXI front end: write address and write data slots,
 * write over read arbitration, command issue toward the queue
 */
`timescale 1ns/1ns
`default_nettype none

module axi_front_end #(
   parameter int ID_WIDTH = 4
) (
   input  wire logic                           bus_clk,
   input  wire logic                           rst,

   input  wire logic                           awvalid,
   output logic                                awready,
   input  wire logic [ID_WIDTH-1:0]            awid,
   input  wire logic [bridge_pkg::ADDR_W-1:0]  awaddr,

   input  wire logic                           wvalid,
   output logic                                wready,
   input  wire logic [bridge_pkg::DATA_W-1:0]  wdata,
   input  wire logic [bridge_pkg::STRB_W-1:0]  wstrb,

   input  wire logic                           arvalid,
   output logic                                arready,
   input  wire logic [ID_WIDTH-1:0]            arid,
   input  wire logic [bridge_pkg::ADDR_W-1:0]  araddr,
   input  wire logic [2:0]                     arsize,

   bridge_cmd_if.source                        cmd
);
   import bridge_pkg::*;

   logic                aw_full;
   logic                w_full;
   logic [ID_WIDTH-1:0] aw_id;
   logic [ADDR_W-1:0]   aw_addr;
   logic [DATA_W-1:0]   w_data;
   logic [STRB_W-1:0]   w_strb;

   logic                wr_pending;
   logic                wr_aligned;
   logic                wr_sent;

   //*******************************************************************
   // Write slots
   //*******************************************************************
   assign awready    = ~aw_full;
   assign wready     = ~w_full;
   assign wr_pending = aw_full & w_full;
   assign wr_sent    = wr_pending & cmd.ready;  // Write always owns the channel here

   always_ff @(posedge bus_clk) begin
      if (rst) begin
         aw_full <= 1'b0;
         w_full  <= 1'b0;
      end else begin
         if (awvalid && awready)
            aw_full <= 1'b1;
         else if (wr_sent)
            aw_full <= 1'b0;

         if (wvalid && wready)
            w_full <= 1'b1;
         else if (wr_sent)
            w_full <= 1'b0;
      end
   end

   always_ff @(posedge bus_clk) begin
      if (awvalid && awready) begin
         aw_id   <= awid;
         aw_addr <= awaddr;
      end
      if (wvalid && wready) begin
         w_data <= wdata;
         w_strb <= wstrb;
      end
   end

   //*******************************************************************
   // Command issue
   //*******************************************************************
   // A complete write blocks the read path until it is accepted
   assign arready    = ~wr_pending & cmd.ready;
   assign wr_aligned = strb_is_aligned(w_strb);

   assign cmd.valid = wr_pending | arvalid;
   assign cmd.write = wr_pending;
   assign cmd.id    = wr_pending ? aw_id : arid;

   // Aligned writes get size and low address from the strobe
   assign cmd.addr = wr_pending ?
                     {aw_addr[ADDR_W-1:3], wr_aligned ? strb_offset(w_strb) : 3'd0} :
                     araddr;
   assign cmd.size = wr_pending ? (wr_aligned ? strb_size(w_strb) : HSIZE_BYTE) : arsize;

   assign cmd.strb  = w_strb;    // Ignored for reads
   assign cmd.wdata = w_data;

endmodule

`default_nettype wire

// File: source/axi_to_ahb_bridge.sv
/*
 * AXI4 to AHB-Lite bridge top level
 * Front end, command queue and AHB master, tied AHB outputs
 */
`timescale 1ns/1ns
`default_nettype none

module axi_to_ahb_bridge #(
   parameter int ID_WIDTH    = 4,
   parameter int QUEUE_DEPTH = 2
) (
   input  wire logic                           bus_clk,
   input  wire logic                           rst,

   // AXI write channels
   input  wire logic                           awvalid,
   output logic                                awready,
   input  wire logic [ID_WIDTH-1:0]            awid,
   input  wire logic [bridge_pkg::ADDR_W-1:0]  awaddr,
   input  wire logic                           wvalid,
   output logic                                wready,
   input  wire logic [bridge_pkg::DATA_W-1:0]  wdata,
   input  wire logic [bridge_pkg::STRB_W-1:0]  wstrb,
   output logic                                bvalid,
   input  wire logic                           bready,
   output logic [ID_WIDTH-1:0]                 bid,
   output logic [1:0]                          bresp,

   // AXI read channels
   input  wire logic                           arvalid,
   output logic                                arready,
   input  wire logic [ID_WIDTH-1:0]            arid,
   input  wire logic [bridge_pkg::ADDR_W-1:0]  araddr,
   input  wire logic [2:0]                     arsize,
   output logic                                rvalid,
   input  wire logic                           rready,
   output logic [ID_WIDTH-1:0]                 rid,
   output logic [bridge_pkg::DATA_W-1:0]       rdata,
   output logic [1:0]                          rresp,
   output logic                                rlast,

   // AHB-Lite master
   output logic [bridge_pkg::ADDR_W-1:0]       haddr,
   output logic [2:0]                          hburst,
   output logic                                hmastlock,
   output logic [3:0]                          hprot,
   output logic [2:0]                          hsize,
   output logic [1:0]                          htrans,
   output logic                                hwrite,
   output logic [bridge_pkg::DATA_W-1:0]       hwdata,
   input  wire logic [bridge_pkg::DATA_W-1:0]  hrdata,
   input  wire logic                           hready,
   input  wire logic                           hresp
);

   bridge_cmd_if #(.ID_WIDTH(ID_WIDTH)) fe_cmd ();
   bridge_cmd_if #(.ID_WIDTH(ID_WIDTH)) mst_cmd ();

   assign rlast     = 1'b1;     // Single beat only
   assign hburst    = 3'b000;   // SINGLE
   assign hmastlock = 1'b0;
   assign hprot     = 4'b0011;  // Privileged data access

   axi_front_end #(.ID_WIDTH(ID_WIDTH)) front_end_i (
      .bus_clk (bus_clk),
      .rst     (rst),
      .awvalid (awvalid),
      .awready (awready),
      .awid    (awid),
      .awaddr  (awaddr),
      .wvalid  (wvalid),
      .wready  (wready),
      .wdata   (wdata),
      .wstrb   (wstrb),
      .arvalid (arvalid),
      .arready (arready),
      .arid    (arid),
      .araddr  (araddr),
      .arsize  (arsize),
      .cmd     (fe_cmd.source)
   );

   cmd_queue #(.ID_WIDTH(ID_WIDTH), .QUEUE_DEPTH(QUEUE_DEPTH)) queue_i (
      .bus_clk (bus_clk),
      .rst     (rst),
      .push    (fe_cmd.sink),
      .pop     (mst_cmd.source)
   );

   ahb_master #(.ID_WIDTH(ID_WIDTH)) master_i (
      .bus_clk (bus_clk),
      .rst     (rst),
      .cmd     (mst_cmd.sink),
      .haddr   (haddr),
      .hsize   (hsize),
      .htrans  (htrans),
      .hwrite  (hwrite),
      .hwdata  (hwdata),
      .hrdata  (hrdata),
      .hready  (hready),
      .hresp   (hresp),
      .bvalid  (bvalid),
      .bready  (bready),
      .bid     (bid),
      .bresp   (bresp),
      .rvalid  (rvalid),
      .rready  (rready),
      .rid     (rid),
      .rdata   (rdata),
      .rresp   (rresp)
   );

endmodule

`default_nettype wire

// File: source/bridge_cmd_if.sv
/*
 * Bridge command channel with valid/ready handshake
 * Producer side is the source modport, consumer side the sink
 */
`timescale 1ns/1ns
`default_nettype none

interface bridge_cmd_if #(
   parameter int ID_WIDTH = 4
);
   import bridge_pkg::*;

   logic                valid;
   logic                ready;
   logic                write;   // 1 = write, 0 = read
   logic [ID_WIDTH-1:0] id;
   logic [ADDR_W-1:0]   addr;
   logic [2:0]          size;
   logic [STRB_W-1:0]   strb;
   logic [DATA_W-1:0]   wdata;

   modport source (output valid, write, id, addr, size, strb, wdata, input ready);
   modport sink   (input valid, write, id, addr, size, strb, wdata, output ready);

endinterface

`default_nettype wire

// File: source/bridge_pkg.sv
/*
 * Bus widths, AHB transfer and size codes, AXI response codes,
 * and the write strobe decode functions shared by the bridge
 */
`default_nettype none

package bridge_pkg;

   localparam int ADDR_W = 32;
   localparam int DATA_W = 64;
   localparam int STRB_W = DATA_W / 8;

   localparam logic [1:0] HTRANS_IDLE   = 2'b00;
   localparam logic [1:0] HTRANS_NONSEQ = 2'b10;

   localparam logic [2:0] HSIZE_BYTE  = 3'd0;
   localparam logic [2:0] HSIZE_HALF  = 3'd1;
   localparam logic [2:0] HSIZE_WORD  = 3'd2;
   localparam logic [2:0] HSIZE_DWORD = 3'd3;

   localparam logic [1:0] RESP_OKAY   = 2'd0;
   localparam logic [1:0] RESP_SLVERR = 2'd2;

   // Strobes that map onto one naturally aligned transfer
   function automatic logic strb_is_aligned(input logic [STRB_W-1:0] strb);
      case (strb)
         8'hff, 8'h0f, 8'hf0, 8'h03, 8'h0c, 8'h30, 8'hc0: return 1'b1;
         default: return 1'b0;
      endcase
   endfunction

   function automatic logic [2:0] strb_size(input logic [STRB_W-1:0] strb);
      case (strb)
         8'hff:                      return HSIZE_DWORD;
         8'h0f, 8'hf0:               return HSIZE_WORD;
         8'h03, 8'h0c, 8'h30, 8'hc0: return HSIZE_HALF;
         default:                    return HSIZE_BYTE;
      endcase
   endfunction

   function automatic logic [2:0] strb_offset(input logic [STRB_W-1:0] strb);
      case (strb)
         8'h0c:        return 3'd2;
         8'hf0, 8'h30: return 3'd4;
         8'hc0:        return 3'd6;
         default:      return 3'd0;
      endcase
   endfunction

   // Lowest set strobe bit at or above start
   function automatic logic [2:0] next_lane(input logic [STRB_W-1:0] strb,
                                            input logic [2:0] start,
                                            output logic found);
      logic [2:0] lane;
      lane  = 3'd0;
      found = 1'b0;
      for (int i = STRB_W - 1; i >= 0; i--) begin
         if (strb[i] && (3'(i) >= start)) begin
            lane  = 3'(i);  // Later hits are lower lanes
            found = 1'b1;
         end
      end
      return lane;
   endfunction

endpackage

`default_nettype wire

// File: source/cmd_queue.sv
/*
 * Circular command FIFO between the AXI and AHB sides
 */
`timescale 1ns/1ns
`default_nettype none

module cmd_queue #(
   parameter int ID_WIDTH    = 4,
   parameter int QUEUE_DEPTH = 2
) (
   input  wire logic  bus_clk,
   input  wire logic  rst,
   bridge_cmd_if.sink   push,
   bridge_cmd_if.source pop
);
   import bridge_pkg::*;

   localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
   localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

   logic                mem_write [QUEUE_DEPTH];
   logic [ID_WIDTH-1:0] mem_id    [QUEUE_DEPTH];
   logic [ADDR_W-1:0]   mem_addr  [QUEUE_DEPTH];
   logic [2:0]          mem_size  [QUEUE_DEPTH];
   logic [STRB_W-1:0]   mem_strb  [QUEUE_DEPTH];
   logic [DATA_W-1:0]   mem_wdata [QUEUE_DEPTH];

   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;
   logic             do_push;
   logic             do_pop;

   assign push.ready = (count != CNT_W'(QUEUE_DEPTH));
   assign pop.valid  = (count != '0);
   assign do_push    = push.valid & push.ready;
   assign do_pop     = pop.valid & pop.ready;

   always_ff @(posedge bus_clk) begin
      if (rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_push)
            wr_ptr <= (wr_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         if (do_pop)
            rd_ptr <= (rd_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         if (do_push && !do_pop)
            count <= count + 1'b1;
         else if (do_pop && !do_push)
            count <= count - 1'b1;
      end
   end

   // Entry storage
   always_ff @(posedge bus_clk) begin
      if (do_push) begin
         mem_write[wr_ptr] <= push.write;
         mem_id[wr_ptr]    <= push.id;
         mem_addr[wr_ptr]  <= push.addr;
         mem_size[wr_ptr]  <= push.size;
         mem_strb[wr_ptr]  <= push.strb;
         mem_wdata[wr_ptr] <= push.wdata;
      end
   end

   assign pop.write = mem_write[rd_ptr];
   assign pop.id    = mem_id[rd_ptr];
   assign pop.addr  = mem_addr[rd_ptr];
   assign pop.size  = mem_size[rd_ptr];
   assign pop.strb  = mem_strb[rd_ptr];
   assign pop.wdata = mem_wdata[rd_ptr];

endmodule

`default_nettype wire

// File: tests/ahb_slave_model.sv
/*
 * AHB-Lite slave model: byte memory, zero to three wait states,
 * two-cycle error response at and above 0xE000_0000
 */
`timescale 1ns/1ns
`default_nettype none

module ahb_slave_model (
   input  wire logic        bus_clk,
   input  wire logic        rst,
   input  wire logic [1:0]  htrans,
   input  wire logic [31:0] haddr,
   input  wire logic [2:0]  hsize,
   input  wire logic        hwrite,
   input  wire logic [63:0] hwdata,
   output logic [63:0]      hrdata,
   output logic             hready,
   output logic             hresp
);
   logic [7:0]  mem [logic [31:0]];
   logic [31:0] seed = 32'd70;
   logic        active;
   logic        err;
   logic [1:0]  waits;
   logic [31:0] addr_q;
   logic [2:0]  size_q;
   logic        write_q;

   function automatic logic [31:0] next_random();
      seed = seed * 32'd1664525 + 32'd1013904223;
      return seed;
   endfunction

   // Unwritten bytes read back a pattern of the full address
   function automatic logic [7:0] read_byte(input logic [31:0] a);
      if (mem.exists(a))
         return mem[a];
      return a[7:0] ^ a[15:8] ^ a[23:16] ^ a[31:24] ^ 8'h5a;
   endfunction

   assign hready = !active || (waits == 2'd0);
   assign hresp  = active && err && (waits <= 2'd1);  // Last two data cycles

   always_comb begin
      for (int i = 0; i < 8; i++)
         hrdata[8*i +: 8] = read_byte({addr_q[31:3], 3'(i)});
   end

   always @(posedge bus_clk) begin : slave_seq
      logic [31:0] r;
      if (rst) begin
         active <= 1'b0;
         waits  <= 2'd0;
         err    <= 1'b0;
      end else begin
         if (active && waits == 2'd0) begin
            if (write_q && !err)
               for (int i = 0; i < (1 << size_q); i++)
                  mem[addr_q + 32'(i)] = hwdata[8*(int'(addr_q[2:0]) + i) +: 8];
            active <= 1'b0;
         end else if (active) begin
            waits <= waits - 2'd1;
         end

         if (htrans == 2'b10) begin  // NONSEQ address phase
            r       = next_random();
            active  <= 1'b1;
            addr_q  <= haddr;
            size_q  <= hsize;
            write_q <= hwrite;
            err     <= (haddr >= 32'hE000_0000);
            if (haddr >= 32'hE000_0000 && r[17:16] == 2'd0)
               waits <= 2'd1;
            else
               waits <= r[17:16];
         end
      end
   end

endmodule

`default_nettype wire

// File: tests/bridge_tb.sv
/*
 * Bridge testbench with clock, reset, AXI stimulus and reference model
 * AHB transfer and AXI response checks, watchdog
 */
`timescale 1ns/1ns
`default_nettype none

module bridge_tb;

   localparam int      N_TXN       = 81;
   localparam longint  WATCHDOG_NS = (longint'(N_TXN) * 200 + 16) * 100;

   logic        bus_clk;
   logic        rst;
   logic        awvalid, wvalid, arvalid, bready, rready;
   logic        awready, wready, arready, bvalid, rvalid, rlast;
   logic [3:0]  awid, arid, bid, rid;
   logic [31:0] awaddr, araddr, haddr;
   logic [63:0] wdata, rdata, hwdata, hrdata;
   logic [7:0]  wstrb;
   logic [2:0]  arsize, hsize, hburst;
   logic [1:0]  bresp, rresp, htrans;
   logic        hwrite, hready, hresp, hmastlock;
   logic [3:0]  hprot;

   logic [31:0] lcg_state = 32'd70;
   logic        hold_resp = 1'b0;
   logic [7:0]  shadow [logic [31:0]];

   // Expected responses and AHB transfers, in command order
   logic        exp_wr[$];
   logic [3:0]  exp_id[$];
   logic [1:0]  exp_resp[$];
   logic [63:0] exp_data[$];
   logic [31:0] xq_addr[$];
   logic [2:0]  xq_size[$];
   logic        xq_write[$];

   axi_to_ahb_bridge #(.ID_WIDTH(4), .QUEUE_DEPTH(2)) dut_i (
      .bus_clk(bus_clk), .rst(rst),
      .awvalid(awvalid), .awready(awready), .awid(awid), .awaddr(awaddr),
      .wvalid(wvalid), .wready(wready), .wdata(wdata), .wstrb(wstrb),
      .bvalid(bvalid), .bready(bready), .bid(bid), .bresp(bresp),
      .arvalid(arvalid), .arready(arready), .arid(arid), .araddr(araddr),
      .arsize(arsize), .rvalid(rvalid), .rready(rready), .rid(rid),
      .rdata(rdata), .rresp(rresp), .rlast(rlast),
      .haddr(haddr), .hburst(hburst), .hmastlock(hmastlock), .hprot(hprot),
      .hsize(hsize), .htrans(htrans), .hwrite(hwrite), .hwdata(hwdata),
      .hrdata(hrdata), .hready(hready), .hresp(hresp)
   );

   ahb_slave_model slave_i (
      .bus_clk(bus_clk), .rst(rst), .htrans(htrans), .haddr(haddr),
      .hsize(hsize), .hwrite(hwrite), .hwdata(hwdata), .hrdata(hrdata),
      .hready(hready), .hresp(hresp)
   );

   initial begin
      bus_clk = 1'b0;
      forever #50 bus_clk = ~bus_clk;
   end

   function automatic logic [31:0] next_random();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   function automatic logic [7:0] shadow_byte(input logic [31:0] a);
      if (shadow.exists(a))
         return shadow[a];
      return a[7:0] ^ a[15:8] ^ a[23:16] ^ a[31:24] ^ 8'h5a;
   endfunction

   //**********************************************************************
   // Reference model
   //**********************************************************************
   function automatic void expect_write(input logic [3:0] id, input logic [31:0] addr,
                                        input logic [63:0] data, input logic [7:0] strb);
      logic        err;
      logic [31:0] base;
      int          lo;
      int          cnt;
      logic        stop;
      err  = (addr >= 32'hE000_0000);
      base = {addr[31:3], 3'b000};
      lo   = 0;
      cnt  = $countones(strb);
      stop = 1'b0;
      for (int i = 7; i >= 0; i--)
         if (strb[i])
            lo = i;
      if (strb inside {8'hff, 8'h0f, 8'hf0, 8'h03, 8'h0c, 8'h30, 8'hc0}) begin
         xq_addr.push_back(base + 32'(lo));
         xq_size.push_back(cnt == 8 ? 3'd3 : (cnt == 4 ? 3'd2 : 3'd1));
         xq_write.push_back(1'b1);
         if (!err)
            for (int i = lo; i < lo + cnt; i++)
               shadow[base + 32'(i)] = data[8*i +: 8];
      end else begin
         for (int i = 0; i < 8; i++) begin
            if (strb[i] && !stop) begin  // One byte per lane, stop on error
               xq_addr.push_back(base + 32'(i));
               xq_size.push_back(3'd0);
               xq_write.push_back(1'b1);
               if (err)
                  stop = 1'b1;
               else
                  shadow[base + 32'(i)] = data[8*i +: 8];
            end
         end
      end
      exp_wr.push_back(1'b1);
      exp_id.push_back(id);
      // An empty strobe makes no AHB transfer and so sees no error
      exp_resp.push_back((err && strb != 8'h00) ? 2'd2 : 2'd0);
      exp_data.push_back('0);
   endfunction

   function automatic void expect_read(input logic [3:0] id, input logic [31:0] addr);
      logic        err;
      logic [63:0] d;
      err = (addr >= 32'hE000_0000);
      for (int i = 0; i < 8; i++)
         d[8*i +: 8] = shadow_byte({addr[31:3], 3'(i)});
      xq_addr.push_back(addr);
      xq_size.push_back(3'd3);
      xq_write.push_back(1'b0);
      exp_wr.push_back(1'b0);
      exp_id.push_back(id);
      exp_resp.push_back(err ? 2'd2 : 2'd0);
      exp_data.push_back(err ? 64'd0 : d);
   endfunction

   task automatic report_mismatch(input string msg);
      $display("MISMATCH at %0t ns: %s", $time, msg);
      $display("TESTS FAILED");
      $fatal(1, "Wrong value from the bridge");
   endtask

   task automatic abort_run(input string msg);
      $display("ERROR at %0t ns: %s", $time, msg);
      $display("TESTS FAILED");
      $fatal(1, "Check failed");
   endtask

   //**********************************************************************
   // AXI stimulus
   //**********************************************************************
   task automatic send_write(input logic [3:0] id, input logic [31:0] addr,
                             input logic [63:0] data, input logic [7:0] strb);
      logic hs_a;
      logic hs_w;
      @(negedge bus_clk);
      awvalid = 1'b1;
      awid    = id;
      awaddr  = addr;
      wvalid  = 1'b1;
      wdata   = data;
      wstrb   = strb;
      while (awvalid || wvalid) begin
         #1;
         hs_a = awvalid && awready;
         hs_w = wvalid && wready;
         @(negedge bus_clk);
         if (hs_a)
            awvalid = 1'b0;
         if (hs_w)
            wvalid = 1'b0;
      end
      expect_write(id, addr, data, strb);
   endtask

   task automatic send_read(input logic [3:0] id, input logic [31:0] addr);
      logic hs;
      @(negedge bus_clk);
      arvalid = 1'b1;
      arid    = id;
      araddr  = addr;
      arsize  = 3'd3;
      do begin
         #1;
         hs = arready;
         @(negedge bus_clk);
      end while (!hs);
      arvalid = 1'b0;
      expect_read(id, addr);
   endtask

   task automatic check_resp(input logic wr, input logic [3:0] id,
                             input logic [1:0] resp, input logic [63:0] data);
      logic        e_wr;
      logic [3:0]  e_id;
      logic [1:0]  e_resp;
      logic [63:0] e_data;
      if (exp_wr.size() == 0)
         abort_run("response arrived with no command outstanding");
      e_wr   = exp_wr.pop_front();
      e_id   = exp_id.pop_front();
      e_resp = exp_resp.pop_front();
      e_data = exp_data.pop_front();
      assert (wr == e_wr)
         else report_mismatch("response on the wrong channel");
      assert (id == e_id)
         else report_mismatch($sformatf("id %0h out of order", id));
      assert (resp == e_resp)
         else report_mismatch($sformatf("resp %0d for id %0h", resp, id));
      if (!wr)
         assert (data == e_data)
            else report_mismatch($sformatf("rdata %h, expected %h", data, e_data));
   endtask

   // Response acceptance with random stalls
   initial begin : resp_sink
      logic [31:0] r;
      bready = 1'b0;
      rready = 1'b0;
      forever begin
         @(negedge bus_clk);
         r      = next_random();
         bready = !hold_resp && (r[9:8] != 2'd0);
         rready = !hold_resp && (r[11:10] != 2'd0);
         #1;
         if (!rst && bvalid && bready)
            check_resp(1'b1, bid, bresp, '0);
         if (!rst && rvalid && rready) begin
            assert (rlast)
               else report_mismatch("rlast low on a read response");
            check_resp(1'b0, rid, rresp, rdata);
         end
      end
   end

   // AHB transfer log against the expected list
   initial begin : xfer_monitor
      logic [31:0] a;
      logic [2:0]  s;
      logic        w;
      forever begin
         @(negedge bus_clk);
         if (!rst && htrans == 2'b10) begin
            if (xq_addr.size() == 0)
               abort_run("AHB transfer with none expected");
            a = xq_addr.pop_front();
            s = xq_size.pop_front();
            w = xq_write.pop_front();
            assert ((haddr & ((32'd1 << hsize) - 32'd1)) == 0)
               else report_mismatch($sformatf("unaligned haddr %h", haddr));
            assert (haddr == a)
               else report_mismatch($sformatf("haddr %h, expected %h", haddr, a));
            assert (hsize == s)
               else report_mismatch($sformatf("hsize %0d at %h", hsize, haddr));
            assert (hwrite == w)
               else report_mismatch($sformatf("hwrite %0b at %h", hwrite, haddr));
            assert (hburst == 3'b000 && !hmastlock && hprot == 4'b0011)
               else report_mismatch($sformatf("hburst %0d hmastlock %0b hprot %b",
                                              hburst, hmastlock, hprot));
         end
      end
   end

   initial begin : watchdog
      #(WATCHDOG_NS);
      $display("ERROR: watchdog expired, the bridge stopped responding");
      $display("TESTS FAILED");
      $fatal(1, "Timeout");
   end

   //**********************************************************************
   // Test sequence
   //**********************************************************************
   localparam logic [7:0] ALIGNED [7] = '{8'hff, 8'h0f, 8'hf0, 8'h03, 8'h0c, 8'h30, 8'hc0};
   localparam logic [7:0] SCATTER [6] = '{8'h05, 8'h81, 8'h7e, 8'h11, 8'h01, 8'hfe};

   initial begin : stimulus
      logic [31:0] r;
      logic [31:0] a;
      rst     = 1'b1;
      awvalid = 1'b0;
      wvalid  = 1'b0;
      arvalid = 1'b0;
      awid    = '0;
      arid    = '0;
      awaddr  = '0;
      araddr  = '0;
      arsize  = 3'd3;
      wdata   = '0;
      wstrb   = '0;
      repeat (16) @(posedge bus_clk);
      @(negedge bus_clk);
      rst = 1'b0;
      #1;
      assert (!bvalid && !rvalid && htrans == 2'b00)
         else abort_run("bridge outputs active after reset");

      for (int i = 0; i < 8; i++)
         send_write(4'(i), 32'h1000 + 32'(8 * i), {next_random(), next_random()}, 8'hff);
      for (int i = 0; i < 8; i++)
         send_read(4'(i + 8), 32'h1000 + 32'(8 * i));

      for (int i = 0; i < 7; i++)
         send_write(4'(i), 32'h2000 + 32'(8 * i), {next_random(), next_random()}, ALIGNED[i]);
      for (int i = 0; i < 7; i++)
         send_read(4'(i), 32'h2000 + 32'(8 * i));

      for (int i = 0; i < 6; i++)
         send_write(4'(i), 32'h3000 + 32'(8 * i), {next_random(), next_random()}, SCATTER[i]);
      for (int i = 0; i < 6; i++)
         send_read(4'(i + 6), 32'h3000 + 32'(8 * i));

      // Error region
      send_write(4'h1, 32'hE000_0000, 64'h1122_3344_5566_7788, 8'hff);
      send_write(4'h2, 32'hE000_0008, 64'h99aa_bbcc_ddee_ff00, 8'h22);
      send_read(4'h3, 32'hE000_0010);
      send_read(4'h4, 32'h3008);

      // Stall starts from an empty bridge
      while (exp_wr.size() != 0)
         @(negedge bus_clk);

      // Fill master and queue, then a write overtakes the stalled read
      hold_resp = 1'b1;
      for (int i = 0; i < 3; i++)
         send_read(4'(i), 32'h1000 + 32'(8 * i));
      fork
         send_read(4'h5, 32'h4000);
         begin
            repeat (3) @(negedge bus_clk);
            send_write(4'h6, 32'h4000, {next_random(), next_random()}, 8'hff);
            hold_resp = 1'b0;
         end
      join

      for (int i = 0; i < 30; i++) begin
         r = next_random();
         a = (r[7:4] == 4'd0) ? 32'hE000_0100 : 32'h4000 + {r[12:8], 3'b000};
         if (r[0])
            send_write(r[19:16], a, {next_random(), next_random()}, r[31:24]);
         else
            send_read(r[19:16], a);
      end

      while (exp_wr.size() != 0)
         @(negedge bus_clk);
      repeat (4) @(negedge bus_clk);
      if (xq_addr.size() != 0) begin
         abort_run("expected AHB transfers never happened");
      end else begin
         $display("TESTS PASSED");
         $finish;
      end
   end

endmodule

`default_nettype wire
